// ==== dbg_core_top.sv ====
// ---------------------------------------
// Debug core top with plain ports
// Bus bridge, debug module and reset unit
// ---------------------------------------
module dbg_core_top (
    input  logic                clk,
    input  logic                arst_n_i,
    input  logic                rst_n_i,
    input  logic                cpu_rst_n_i,
    output logic                core_rst_n_o,
    output logic                core_rdc_qlfy_o,
    // Fuse
    input  dbg_pkg::dmi_data_t  hart_id_fuse_i,
    // AXI4-Lite slave
    input  logic                s_awvalid_i,
    output logic                s_awready_o,
    input  dbg_pkg::axil_addr_t s_awaddr_i,
    input  logic                s_wvalid_i,
    output logic                s_wready_o,
    input  dbg_pkg::dmi_data_t  s_wdata_i,
    input  logic [3:0]          s_wstrb_i,
    output logic                s_bvalid_o,
    input  logic                s_bready_i,
    output logic [1:0]          s_bresp_o,
    input  logic                s_arvalid_i,
    output logic                s_arready_o,
    input  dbg_pkg::axil_addr_t s_araddr_i,
    output logic                s_rvalid_o,
    input  logic                s_rready_i,
    output dbg_pkg::dmi_data_t  s_rdata_o,
    output logic [1:0]          s_rresp_o,
    // Hart run control
    output logic                hart_cmd_req_o,
    output dbg_pkg::hart_cmd_e  hart_cmd_o,
    input  logic                hart_cmd_resp_i,
    input  logic                hart_halted_i
);

    logic ndm_rst_req;

    dmi_if dmi ();

    // ---------------------------------------
    // Bus side
    // ---------------------------------------
    dmi_axil_bridge i_bridge (
        .clk          (clk        ),
        .arst_n_i     (arst_n_i   ),
        .dmi          (dmi.master ),
        .s_awvalid_i  (s_awvalid_i),
        .s_awready_o  (s_awready_o),
        .s_awaddr_i   (s_awaddr_i ),
        .s_wvalid_i   (s_wvalid_i ),
        .s_wready_o   (s_wready_o ),
        .s_wdata_i    (s_wdata_i  ),
        .s_wstrb_i    (s_wstrb_i  ),
        .s_bvalid_o   (s_bvalid_o ),
        .s_bready_i   (s_bready_i ),
        .s_bresp_o    (s_bresp_o  ),
        .s_arvalid_i  (s_arvalid_i),
        .s_arready_o  (s_arready_o),
        .s_araddr_i   (s_araddr_i ),
        .s_rvalid_o   (s_rvalid_o ),
        .s_rready_i   (s_rready_i ),
        .s_rdata_o    (s_rdata_o  ),
        .s_rresp_o    (s_rresp_o  )
    );

    dm_ctrl i_dm (
        .clk             (clk            ),
        .arst_n_i        (arst_n_i       ),   // Survives ndmreset
        .dmi             (dmi.slave      ),
        .hart_id_fuse_i  (hart_id_fuse_i ),
        .core_rdc_qlfy_i (core_rdc_qlfy_o),
        .ndm_rst_req_o   (ndm_rst_req    ),
        .hart_cmd_req_o  (hart_cmd_req_o ),
        .hart_cmd_o      (hart_cmd_o     ),
        .hart_cmd_resp_i (hart_cmd_resp_i),
        .hart_halted_i   (hart_halted_i  )
    );

    // ---------------------------------------
    // Reset side
    // ---------------------------------------
    rst_ctrl_unit i_rst (
        .clk             (clk            ),
        .arst_n_i        (arst_n_i       ),
        .rst_n_i         (rst_n_i        ),
        .cpu_rst_n_i     (cpu_rst_n_i    ),
        .ndm_rst_req_i   (ndm_rst_req    ),
        .core_rst_n_o    (core_rst_n_o   ),
        .core_rdc_qlfy_o (core_rdc_qlfy_o)
    );

endmodule : dbg_core_top

// ==== dbg_golden.txt ====
# op  addr  wdata     expected  cmd_count   (hex fields)
# RST: wdata = {rst_n_i, cpu_rst_n_i}, expected = core_rst_n_o level
RST 000 00000003 00000001 0
R   044 00000000 00000800 0
W   010 12345678 00000000 0
R   010 00000000 00000000 0
W   040 00000001 00000000 0
R   040 00000000 00000001 0
W   010 CAFE1234 00000000 0
R   010 00000000 CAFE1234 0
R   048 00000000 00000A5C 0
W   040 80000001 00000000 1
R   044 00000000 00000200 1
W   040 40000001 00000000 2
R   044 00000000 00000800 2
W   040 C0000001 00000000 3
R   044 00000000 00000200 3
W   040 40000001 00000000 4
W   040 00000003 00000000 4
RST 000 00000003 00000000 4
R   044 00000000 00002000 4
R   040 00000000 00000003 4
W   040 80000003 00000000 4
W   040 00000001 00000000 4
RST 000 00000003 00000001 4
R   044 00000000 00000800 4
RST 000 00000002 00000000 4
RST 000 00000003 00000001 4
R   010 00000000 CAFE1234 4

// ==== dbg_pkg.sv ====
// ---------------------------------------
// Shared widths, register map and FSM
// encodings of the debug core slice
// ---------------------------------------
package dbg_pkg;

    // Vector types
    typedef logic [8:0]  axil_addr_t;   // AXI4-Lite byte address
    typedef logic [6:0]  dmi_addr_t;    // DMI register address
    typedef logic [31:0] dmi_data_t;    // DMI/AXI data word, fuse value

    // Run-control command to the hart
    typedef enum logic {
        HART_CMD_HALT   = 1'b0,
        HART_CMD_RESUME = 1'b1
    } hart_cmd_e;

    typedef enum logic [1:0] {
        DM_IDLE     = 2'd0,
        DM_RESP     = 2'd1,
        DM_CMD_WAIT = 2'd2
    } dm_state_e;

    typedef enum logic [1:0] {
        AXIL_IDLE     = 2'd0,
        AXIL_DMI_WAIT = 2'd1,
        AXIL_BRESP    = 2'd2,
        AXIL_RRESP    = 2'd3
    } axil_state_e;

    localparam int unsigned RST_SYNC_STAGES = 2;

    // Debug module register map
    localparam dmi_addr_t DM_ADDR_DATA0     = 7'h04;
    localparam dmi_addr_t DM_ADDR_DMCONTROL = 7'h10;
    localparam dmi_addr_t DM_ADDR_DMSTATUS  = 7'h11;
    localparam dmi_addr_t DM_ADDR_HARTINFO  = 7'h12;

    // dmcontrol fields
    localparam int unsigned DMCTRL_DMACTIVE_BIT  = 0;
    localparam int unsigned DMCTRL_NDMRESET_BIT  = 1;
    localparam int unsigned DMCTRL_RESUMEREQ_BIT = 30;
    localparam int unsigned DMCTRL_HALTREQ_BIT   = 31;

    // dmstatus fields
    localparam int unsigned DMSTAT_ALLHALTED_BIT  = 9;
    localparam int unsigned DMSTAT_ALLRUNNING_BIT = 11;
    localparam int unsigned DMSTAT_ALLUNAVAIL_BIT = 13;

    localparam logic [1:0] AXIL_RESP_OKAY = 2'b00;

endpackage : dbg_pkg

// ==== dm_ctrl.sv ====
// ---------------------------------------
// Debug module control
// Serves data0, dmcontrol, dmstatus and hartinfo
// over DMI and issues hart halt/resume commands
// ---------------------------------------
module dm_ctrl (
    input  logic               clk,
    input  logic               arst_n_i,
    dmi_if.slave               dmi,
    input  dbg_pkg::dmi_data_t hart_id_fuse_i,
    input  logic               core_rdc_qlfy_i,    // Core out of reset
    output logic               ndm_rst_req_o,
    output logic               hart_cmd_req_o,
    output dbg_pkg::hart_cmd_e hart_cmd_o,
    input  logic               hart_cmd_resp_i,
    input  logic               hart_halted_i
);
    import dbg_pkg::*;

    dm_state_e state_q;
    dm_state_e state_next;
    logic      dmactive_q;
    logic      ndmreset_q;
    logic      cmd_req_q;
    hart_cmd_e cmd_q;
    dmi_data_t data0_q;
    dmi_data_t rdata_q;
    dmi_data_t rd_mux;
    logic      halted_qlfy;
    logic      cmd_resp_qlfy;
    logic      acc;
    logic      wr_ctrl;
    logic      halt_req;
    logic      resume_req;
    logic      cmd_start;
    logic      cmd_done;

    // Hart signals are only trusted while the core is out of reset
    assign halted_qlfy   = hart_halted_i & core_rdc_qlfy_i;
    assign cmd_resp_qlfy = hart_cmd_resp_i & core_rdc_qlfy_i;

    assign acc        = (state_q == DM_IDLE) & dmi.req;
    assign wr_ctrl    = acc & dmi.wr & (dmi.addr == DM_ADDR_DMCONTROL);
    assign halt_req   = dmi.wdata[DMCTRL_HALTREQ_BIT];
    assign resume_req = dmi.wdata[DMCTRL_RESUMEREQ_BIT];
    assign cmd_start  = wr_ctrl & dmactive_q & dmi.wdata[DMCTRL_DMACTIVE_BIT]
                      & core_rdc_qlfy_i & (halt_req | resume_req);
    // Response from the hart, or the core went away meanwhile
    assign cmd_done   = cmd_resp_qlfy | ~core_rdc_qlfy_i;

    // ---------------------------------------
    // Register read mux
    // ---------------------------------------
    always_comb begin
        rd_mux = '0;
        case (dmi.addr)
            DM_ADDR_DATA0: begin
                if (dmactive_q) begin
                    rd_mux = data0_q;
                end
            end
            DM_ADDR_DMCONTROL: begin
                rd_mux[DMCTRL_DMACTIVE_BIT] = dmactive_q;
                rd_mux[DMCTRL_NDMRESET_BIT] = ndmreset_q;
            end
            DM_ADDR_DMSTATUS: begin
                rd_mux[DMSTAT_ALLHALTED_BIT]  = halted_qlfy;
                rd_mux[DMSTAT_ALLRUNNING_BIT] = core_rdc_qlfy_i & ~halted_qlfy;
                rd_mux[DMSTAT_ALLUNAVAIL_BIT] = ~core_rdc_qlfy_i;
            end
            DM_ADDR_HARTINFO: rd_mux = hart_id_fuse_i;
            default:          rd_mux = '0;
        endcase
    end

    // ---------------------------------------
    // Access and run-control FSM
    // ---------------------------------------
    always_comb begin
        state_next = state_q;
        case (state_q)
            DM_IDLE: begin
                if (cmd_start) begin
                    state_next = DM_CMD_WAIT;
                end else if (dmi.req) begin
                    state_next = DM_RESP;
                end
            end
            DM_CMD_WAIT: begin
                if (cmd_done) begin
                    state_next = DM_RESP;
                end
            end
            default: state_next = DM_IDLE;  // DM_RESP lasts one cycle
        endcase
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q    <= DM_IDLE;
            dmactive_q <= 1'b0;
            ndmreset_q <= 1'b0;
            cmd_req_q  <= 1'b0;
            cmd_q      <= HART_CMD_HALT;
        end else begin
            state_q <= state_next;
            if (wr_ctrl) begin
                dmactive_q <= dmi.wdata[DMCTRL_DMACTIVE_BIT];
                if (dmactive_q) begin
                    // Deactivation also drops ndmreset
                    ndmreset_q <= dmi.wdata[DMCTRL_NDMRESET_BIT]
                                & dmi.wdata[DMCTRL_DMACTIVE_BIT];
                end
            end
            if (cmd_start) begin
                cmd_req_q <= 1'b1;
                cmd_q     <= halt_req ? HART_CMD_HALT : HART_CMD_RESUME;  // Halt first
            end else if ((state_q == DM_CMD_WAIT) && cmd_done) begin
                cmd_req_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (acc && dmi.wr && dmactive_q && (dmi.addr == DM_ADDR_DATA0)) begin
            data0_q <= dmi.wdata;
        end
        if (acc) begin
            rdata_q <= dmi.wr ? '0 : rd_mux;
        end
    end

    assign dmi.resp  = (state_q == DM_RESP);
    assign dmi.rdata = rdata_q;

    assign ndm_rst_req_o  = ndmreset_q;
    assign hart_cmd_req_o = cmd_req_q;
    assign hart_cmd_o     = cmd_q;

endmodule : dm_ctrl

// ==== dmi_axil_bridge.sv ====
// ---------------------------------------
// AXI4-Lite slave for the debug module
// Each bus transaction becomes one DMI request
// Full-word access only, AW and W come together
// ---------------------------------------
module dmi_axil_bridge (
    input  logic                clk,
    input  logic                arst_n_i,
    dmi_if.master               dmi,
    // Write address and data
    input  logic                s_awvalid_i,
    output logic                s_awready_o,
    input  dbg_pkg::axil_addr_t s_awaddr_i,
    input  logic                s_wvalid_i,
    output logic                s_wready_o,
    input  dbg_pkg::dmi_data_t  s_wdata_i,
    input  logic [3:0]          s_wstrb_i,      // Byte lanes not supported
    // Write response
    output logic                s_bvalid_o,
    input  logic                s_bready_i,
    output logic [1:0]          s_bresp_o,
    // Read address and data
    input  logic                s_arvalid_i,
    output logic                s_arready_o,
    input  dbg_pkg::axil_addr_t s_araddr_i,
    output logic                s_rvalid_o,
    input  logic                s_rready_i,
    output dbg_pkg::dmi_data_t  s_rdata_o,
    output logic [1:0]          s_rresp_o
);
    import dbg_pkg::*;

    axil_state_e state_q;
    axil_state_e state_next;
    logic        idle_rdy_q;    // All address/data readies
    logic        bvalid_q;
    logic        rvalid_q;
    logic        wr_q;          // Current DMI op is a write
    logic        pend_wr_q;     // Write taken together with a read
    dmi_addr_t   rd_addr_q;
    dmi_addr_t   wr_addr_q;
    dmi_data_t   wdata_q;
    dmi_data_t   rdata_q;
    logic        rd_take;
    logic        wr_take;

    assign rd_take = idle_rdy_q & s_arvalid_i;
    assign wr_take = idle_rdy_q & s_awvalid_i & s_wvalid_i;

    // ---------------------------------------
    // Transaction FSM
    // ---------------------------------------
    always_comb begin
        state_next = state_q;
        case (state_q)
            AXIL_IDLE: begin
                if (rd_take || wr_take) begin
                    state_next = AXIL_DMI_WAIT;
                end
            end
            AXIL_DMI_WAIT: begin
                if (dmi.resp) begin
                    state_next = wr_q ? AXIL_BRESP : AXIL_RRESP;
                end
            end
            AXIL_BRESP: begin
                if (s_bready_i) begin
                    state_next = AXIL_IDLE;
                end
            end
            AXIL_RRESP: begin
                if (s_rready_i) begin
                    // Read went first, now serve the held write
                    state_next = pend_wr_q ? AXIL_DMI_WAIT : AXIL_IDLE;
                end
            end
            default: state_next = AXIL_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q    <= AXIL_IDLE;
            idle_rdy_q <= 1'b0;
            bvalid_q   <= 1'b0;
            rvalid_q   <= 1'b0;
            wr_q       <= 1'b0;
            pend_wr_q  <= 1'b0;
        end else begin
            state_q    <= state_next;
            idle_rdy_q <= (state_next == AXIL_IDLE);
            bvalid_q   <= (state_next == AXIL_BRESP);
            rvalid_q   <= (state_next == AXIL_RRESP);
            if (rd_take) begin
                wr_q      <= 1'b0;
                pend_wr_q <= wr_take;   // Read wins
            end else if (wr_take) begin
                wr_q <= 1'b1;
            end else if ((state_q == AXIL_RRESP) && s_rready_i && pend_wr_q) begin
                wr_q      <= 1'b1;
                pend_wr_q <= 1'b0;
            end
        end
    end

    // Address, write data and read data holding
    always_ff @(posedge clk) begin
        if (rd_take) begin
            rd_addr_q <= s_araddr_i[8:2];
        end
        if (wr_take) begin
            wr_addr_q <= s_awaddr_i[8:2];
            wdata_q   <= s_wdata_i;
        end
        if ((state_q == AXIL_DMI_WAIT) && dmi.resp && !wr_q) begin
            rdata_q <= dmi.rdata;   // Held until rready
        end
    end

    // ---------------------------------------
    // Outputs
    // ---------------------------------------
    assign dmi.req   = (state_q == AXIL_DMI_WAIT);
    assign dmi.wr    = wr_q;
    assign dmi.addr  = wr_q ? wr_addr_q : rd_addr_q;
    assign dmi.wdata = wdata_q;

    assign s_awready_o = idle_rdy_q;
    assign s_wready_o  = idle_rdy_q;
    assign s_arready_o = idle_rdy_q;
    assign s_bvalid_o  = bvalid_q;
    assign s_bresp_o   = AXIL_RESP_OKAY;
    assign s_rvalid_o  = rvalid_q;
    assign s_rdata_o   = rdata_q;
    assign s_rresp_o   = AXIL_RESP_OKAY;

endmodule : dmi_axil_bridge

// ==== dmi_if.sv ====
// ---------------------------------------
// DMI link between the bus bridge and the
// debug module, one request in flight
// ---------------------------------------
interface dmi_if;
    import dbg_pkg::*;

    logic      req;     // Held until resp
    logic      wr;
    dmi_addr_t addr;
    dmi_data_t wdata;
    logic      resp;    // Single-cycle pulse
    dmi_data_t rdata;   // Valid with resp

    modport master (
        output req, wr, addr, wdata,
        input  resp, rdata
    );

    modport slave (
        input  req, wr, addr, wdata,
        output resp, rdata
    );

endinterface : dmi_if

// ==== filelist.f ====
dbg_pkg.sv
dmi_if.sv
dmi_axil_bridge.sv
dm_ctrl.sv
rst_ctrl_unit.sv
dbg_core_top.sv
tb_dbg_core_top.sv

// ==== rst_ctrl_unit.sv ====
// ---------------------------------------
// Core reset generation
// Combines reset sources, synchronizes the
// release and marks when the core is usable
// ---------------------------------------
module rst_ctrl_unit (
    input  logic clk,
    input  logic arst_n_i,
    input  logic rst_n_i,
    input  logic cpu_rst_n_i,
    input  logic ndm_rst_req_i,     // From the debug module
    output logic core_rst_n_o,
    output logic core_rdc_qlfy_o
);
    import dbg_pkg::*;

    logic                       core_rst_req_n;
    logic [RST_SYNC_STAGES-1:0] sync_q;
    logic                       qlfy_q;

    // Core held in reset while any source asks for it
    assign core_rst_req_n = rst_n_i & cpu_rst_n_i & ~ndm_rst_req_i;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            sync_q <= '0;
            qlfy_q <= 1'b0;
        end else begin
            sync_q <= {sync_q[RST_SYNC_STAGES-2:0], core_rst_req_n};
            // Sets a cycle after release, clears with the core reset
            qlfy_q <= sync_q[RST_SYNC_STAGES-1] & sync_q[RST_SYNC_STAGES-2];
        end
    end

    assign core_rst_n_o    = sync_q[RST_SYNC_STAGES-1];
    assign core_rdc_qlfy_o = qlfy_q;

endmodule : rst_ctrl_unit

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the debug core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_dbg_core_top -f filelist.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_dbg_core_top 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "=== PASS ==="; then
    exit 0
fi
exit 1

// ==== tb_dbg_core_top.sv ====
// ---------------------------------------
// Testbench for the debug core top
// Replays bus operations from the golden file
// against an AXI4-Lite driver and a hart model
// ---------------------------------------
module tb_dbg_core_top;
    import dbg_pkg::*;

    localparam int unsigned WAIT_LIMIT = 200;
    localparam dmi_data_t   FUSE_ID    = 32'h0000_0A5C;

    logic       clk;
    logic       arst_n_i;
    logic       rst_n_i;
    logic       cpu_rst_n_i;
    logic       core_rst_n_o;
    logic       core_rdc_qlfy_o;
    dmi_data_t  hart_id_fuse_i;
    logic       s_awvalid_i;
    logic       s_awready_o;
    axil_addr_t s_awaddr_i;
    logic       s_wvalid_i;
    logic       s_wready_o;
    dmi_data_t  s_wdata_i;
    logic [3:0] s_wstrb_i;
    logic       s_bvalid_o;
    logic       s_bready_i;
    logic [1:0] s_bresp_o;
    logic       s_arvalid_i;
    logic       s_arready_o;
    axil_addr_t s_araddr_i;
    logic       s_rvalid_o;
    logic       s_rready_i;
    dmi_data_t  s_rdata_o;
    logic [1:0] s_rresp_o;
    logic       hart_cmd_req_o;
    hart_cmd_e  hart_cmd_o;
    logic       hart_cmd_resp_i;
    logic       hart_halted_i;

    logic [31:0] cmd_count;     // Commands seen by the hart model
    hart_cmd_e   last_cmd;
    logic [31:0] rnd_state;

    dbg_core_top DUT (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ---------------------------------------
    // Checks and failure reporting
    // ---------------------------------------
    task automatic fail_stop(input string msg);
        $display("%s", msg);
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic timeout_fail(input string what);
        fail_stop($sformatf("Timeout: %s did not happen within %0d cycles", what, WAIT_LIMIT));
    endtask

    task automatic check_data(input string what, input dmi_data_t got, input dmi_data_t exp);
        if (got !== exp) begin
            fail_stop($sformatf("ERR %0t: %s got %h, expected %h", $time, what, got, exp));
        end
    endtask

    task automatic check_cmd(input string what, input hart_cmd_e got, input hart_cmd_e exp);
        if (got !== exp) begin
            fail_stop($sformatf("ERR %0t: %s got %s, expected %s",
                                $time, what, got.name(), exp.name()));
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            fail_stop($sformatf("ERR %0t: %s got %b, expected %b", $time, what, got, exp));
        end
    endtask

    // ---------------------------------------
    // AXI4-Lite driver
    // ---------------------------------------
    task automatic axil_write(input axil_addr_t addr, input dmi_data_t data);
        logic [31:0] n;
        s_awaddr_i  = addr;
        s_wdata_i   = data;
        s_awvalid_i = 1'b1;
        s_wvalid_i  = 1'b1;
        n = 0;
        while (!(s_awready_o && s_wready_o)) begin
            @(negedge clk);
            n = n + 1;
            if (n > WAIT_LIMIT) timeout_fail("write address accept");
        end
        @(negedge clk);             // Taken on the edge in between
        s_awvalid_i = 1'b0;
        s_wvalid_i  = 1'b0;
        s_bready_i  = 1'b1;
        n = 0;
        while (!s_bvalid_o) begin
            @(negedge clk);
            n = n + 1;
            if (n > WAIT_LIMIT) timeout_fail("write response");
        end
        check_data("write response code", {30'd0, s_bresp_o}, {30'd0, AXIL_RESP_OKAY});
        @(negedge clk);
        s_bready_i = 1'b0;
    endtask

    task automatic axil_read(input axil_addr_t addr, output dmi_data_t data);
        logic [31:0] n;
        s_araddr_i  = addr;
        s_arvalid_i = 1'b1;
        n = 0;
        while (!s_arready_o) begin
            @(negedge clk);
            n = n + 1;
            if (n > WAIT_LIMIT) timeout_fail("read address accept");
        end
        @(negedge clk);
        s_arvalid_i = 1'b0;
        s_rready_i  = 1'b1;
        n = 0;
        while (!s_rvalid_o) begin
            @(negedge clk);
            n = n + 1;
            if (n > WAIT_LIMIT) timeout_fail("read data");
        end
        data = s_rdata_o;
        check_data("read response code", {30'd0, s_rresp_o}, {30'd0, AXIL_RESP_OKAY});
        @(negedge clk);
        s_rready_i = 1'b0;
    endtask

    // Drive the reset sources and follow the core reset
    task automatic apply_reset(input logic [1:0] levels, input logic exp_core);
        logic [31:0] n;
        logic        changed;
        changed     = (levels != {rst_n_i, cpu_rst_n_i});
        rst_n_i     = levels[1];
        cpu_rst_n_i = levels[0];
        n = 0;
        while (core_rst_n_o !== exp_core) begin
            @(negedge clk);
            n = n + 1;
            if (n > WAIT_LIMIT) timeout_fail("core reset change");
        end
        if (changed && (n != 0)) begin
            check_data("core reset latency in cycles", n, 32'd2);
        end
        if (!exp_core) begin
            check_bit("qualifier in core reset", core_rdc_qlfy_o, 1'b0);
        end else if (n != 0) begin
            check_bit("qualifier at core reset release", core_rdc_qlfy_o, 1'b0);
            @(negedge clk);
            check_bit("qualifier one cycle after release", core_rdc_qlfy_o, 1'b1);
        end else begin
            n = 0;
            while (core_rdc_qlfy_o !== 1'b1) begin
                @(negedge clk);
                n = n + 1;
                if (n > WAIT_LIMIT) timeout_fail("qualifier set");
            end
        end
    endtask

    function automatic logic [31:0] next_random(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // ---------------------------------------
    // Hart model
    // ---------------------------------------
    initial begin
        logic [31:0] delay;
        rnd_state       = 32'd56556;
        cmd_count       = '0;
        last_cmd        = HART_CMD_HALT;
        hart_cmd_resp_i = 1'b0;
        hart_halted_i   = 1'b0;
        forever begin
            @(negedge clk);
            if (hart_cmd_req_o) begin
                last_cmd  = hart_cmd_o;
                cmd_count = cmd_count + 32'd1;
                rnd_state = next_random(rnd_state);
                delay     = {30'd0, rnd_state[1:0]};
                repeat (delay) @(negedge clk);
                hart_cmd_resp_i = 1'b1;
                hart_halted_i   = (last_cmd == HART_CMD_HALT);
                @(negedge clk);
                hart_cmd_resp_i = 1'b0;
            end
        end
    end

    // ---------------------------------------
    // Golden file replay
    // ---------------------------------------
    initial begin
        int          fd;
        int          code;
        string       op;
        string       line;
        logic [31:0] addr_f;
        logic [31:0] wdata_f;
        logic [31:0] exp_f;
        logic [31:0] cnt_f;
        logic [31:0] prev_count;
        dmi_data_t   rd;
        arst_n_i       = 1'b0;
        rst_n_i        = 1'b0;
        cpu_rst_n_i    = 1'b0;
        hart_id_fuse_i = FUSE_ID;
        s_awvalid_i    = 1'b0;
        s_awaddr_i     = '0;
        s_wvalid_i     = 1'b0;
        s_wdata_i      = '0;
        s_wstrb_i      = 4'hF;
        s_bready_i     = 1'b0;
        s_arvalid_i    = 1'b0;
        s_araddr_i     = '0;
        s_rready_i     = 1'b0;
        repeat (10) @(negedge clk);
        check_bit("core reset during power-up", core_rst_n_o, 1'b0);
        check_bit("qualifier during power-up", core_rdc_qlfy_o, 1'b0);
        check_bit("awready during power-up", s_awready_o, 1'b0);
        check_bit("wready during power-up", s_wready_o, 1'b0);
        check_bit("arready during power-up", s_arready_o, 1'b0);
        check_bit("bvalid during power-up", s_bvalid_o, 1'b0);
        check_bit("rvalid during power-up", s_rvalid_o, 1'b0);
        check_bit("command request during power-up", hart_cmd_req_o, 1'b0);
        arst_n_i = 1'b1;
        @(negedge clk);             // Readies up on the first edge
        check_bit("awready after reset release", s_awready_o, 1'b1);
        check_bit("wready after reset release", s_wready_o, 1'b1);
        check_bit("arready after reset release", s_arready_o, 1'b1);

        fd = $fopen("dbg_golden.txt", "r");
        if (fd == 0) fail_stop("Cannot open golden file dbg_golden.txt");
        while ($fscanf(fd, "%s", op) == 1) begin
            if (op.getc(0) == "#") begin
                code = $fgets(line, fd);
            end else begin
                code = $fscanf(fd, "%h %h %h %h", addr_f, wdata_f, exp_f, cnt_f);
                if (code != 4) fail_stop("Malformed line in golden file");
                prev_count = cmd_count;
                if (op == "W") begin
                    axil_write(addr_f[8:0], wdata_f);
                    if (cmd_count != prev_count) begin
                        check_cmd("issued command", last_cmd,
                                  wdata_f[DMCTRL_HALTREQ_BIT] ? HART_CMD_HALT : HART_CMD_RESUME);
                    end
                end else if (op == "R") begin
                    axil_read(addr_f[8:0], rd);
                    check_data($sformatf("read of address %h", addr_f[8:0]), rd, exp_f);
                end else if (op == "RST") begin
                    apply_reset(wdata_f[1:0], exp_f[0]);
                end else begin
                    fail_stop($sformatf("Unknown operation %s in golden file", op));
                end
                check_data("command count", cmd_count, cnt_f);
            end
        end
        $fclose(fd);
        $display("=== PASS ===");
        $finish;
    end

endmodule : tb_dbg_core_top
